/* calib_ptngen.f */
src/calib_pkg.sv
src/cal_cfg_if.sv
src/ptn_data_gen.sv
src/march_seq.sv
src/resp_capture.sv
src/result_ram.sv
src/calib_ptngen.sv
dv/tb_calib_ptngen.sv

/* dv/tb_calib_ptngen.sv */
`timescale 1ns/1ps

module tb_calib_ptngen;

  localparam int ROWS_PER_COL  = 64;     // Row walk length before the column steps
  localparam int DONE_TIMEOUT  = 20000;  // Cycles allowed for one run
  localparam int SETTLE_CYCLES = 4;

  typedef logic [calib_pkg::ROW_W-1:0]  row_t;
  typedef logic [calib_pkg::COL_W-1:0]  col_t;
  typedef logic [calib_pkg::DATA_W-1:0] word_t;
  typedef logic [calib_pkg::RES_AW-1:0] rptr_t;

  logic                        clk;
  logic                        rst;
  logic                        cal_pgen_start;
  calib_pkg::march_e           march_type;
  calib_pkg::data_e            data_type;
  logic [calib_pkg::LEN_W-1:0] march_len;
  rptr_t                       pgen_rd_ptr;
  word_t                       pgen_dout;
  logic                        pgen_done;
  logic                        sched_rdy;
  logic                        pgen_pkt_valid;
  calib_pkg::pkt_t             pgen_pkt;
  logic                        intf_pkt_valid;
  calib_pkg::pkt_t             intf_pkt;

  // Stimulus table with one entry per run
  string             tbl_name[$];
  calib_pkg::march_e tbl_mt[$];
  calib_pkg::data_e  tbl_dt[$];
  int unsigned       tbl_len[$];
  int                tbl_xfers[$];  // Expected transfers (2N or 0)

  // Current run state shared with the bus model
  string            cur_name = "reset";
  calib_pkg::data_e cur_dt = calib_pkg::DT_ZERO;
  int               cur_n = 0;
  int               xfer_cnt = 0;
  int               valid_cycles = 0;
  int               done_cnt = 0;
  int               rsp_sent = 0;
  int               rsp_at_done = -1;
  int               rd_q[$];        // Read indexes waiting for a response
  word_t            rb_q[$];        // Response data in arrival order

  int err_cnt = 0;
  int chk_cnt = 0;
  bit timed_out = 1'b0;

  calib_ptngen u_dut (
    .clk            (clk),
    .rst            (rst),
    .cal_pgen_start (cal_pgen_start),
    .march_type     (march_type),
    .data_type      (data_type),
    .march_len      (march_len),
    .pgen_rd_ptr    (pgen_rd_ptr),
    .pgen_dout      (pgen_dout),
    .pgen_done      (pgen_done),
    .sched_rdy      (sched_rdy),
    .pgen_pkt_valid (pgen_pkt_valid),
    .pgen_pkt       (pgen_pkt),
    .intf_pkt_valid (intf_pkt_valid),
    .intf_pkt       (intf_pkt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reference data word for a data type at a row and column in bank 0
  function automatic word_t pattern_word(calib_pkg::data_e dt, row_t row, col_t col);
    word_t w;
    int    i;
    w = '0;
    case (dt)
      calib_pkg::DT_ONE: w = '1;
      calib_pkg::DT_HALF: begin
        for (i = 0; i < calib_pkg::DATA_W / 2; i++) w[i] = 1'b1;  // Low half set
      end
      calib_pkg::DT_W16: begin
        for (i = 0; i < calib_pkg::DATA_W; i += 32) w[i +: 32] = 32'h0000FFFF;
      end
      calib_pkg::DT_CHECK: begin
        for (i = 0; i < calib_pkg::DATA_W; i += 32) w[i +: 32] = 32'hAAAA5555;
      end
      calib_pkg::DT_ADDR: begin
        w[calib_pkg::COL_W-1:0]     = col;  // Column in bits 15:0
        w[16 +: calib_pkg::ROW_W]   = row;  // Row in bits 31:16 with the bank byte left at 0
      end
      default: w = '0;
    endcase
    return w;
  endfunction

  // Distinct marker per response so ordering errors show up in readback
  function automatic word_t tag_word(int idx);
    word_t w;
    int    j;
    for (j = 0; j < calib_pkg::DATA_W / 32; j++) begin
      w[j*32 +: 32] = ((idx + 1) * 32'h01010101) ^ (j << 4);
    end
    return w;
  endfunction

  // Packet number idx of a run with N writes followed by N reads over the same walk
  function automatic calib_pkg::pkt_t expected_pkt(int idx, int n, calib_pkg::data_e dt);
    calib_pkg::pkt_t p;
    int              pos;
    pos        = (idx < n) ? idx : idx - n;
    p.req_type = (idx < n) ? calib_pkg::WRITE : calib_pkg::READ;
    p.bk_addr  = '0;
    p.row_addr = row_t'(pos % ROWS_PER_COL);
    p.col_addr = col_t'(pos / ROWS_PER_COL);
    p.data     = pattern_word(dt, p.row_addr, p.col_addr);
    p.prio     = '0;
    return p;
  endfunction

  task automatic check_pkt(string name, calib_pkg::pkt_t exp_val, calib_pkg::pkt_t act_val);
    chk_cnt++;
    if (act_val !== exp_val) begin
      err_cnt++;
      $display("** Error %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_data(string name, word_t exp_val, word_t act_val);
    chk_cnt++;
    if (act_val !== exp_val) begin
      err_cnt++;
      $display("** Error %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_count(string name, int exp_val, int act_val);
    chk_cnt++;
    if (act_val != exp_val) begin
      err_cnt++;
      $display("** Error %s: expected %0d, actual %0d", name, exp_val, act_val);
    end
  endtask

  task automatic add_row(string name, calib_pkg::march_e mt, calib_pkg::data_e dt,
                         int unsigned len, int xfers);
    tbl_name.push_back(name);
    tbl_mt.push_back(mt);
    tbl_dt.push_back(dt);
    tbl_len.push_back(len);
    tbl_xfers.push_back(xfers);
  endtask

  task automatic load_table();
    add_row("zero_len5",   calib_pkg::XMARCH,      calib_pkg::DT_ZERO,  5,   10);
    add_row("ones_len1",   calib_pkg::XMARCH,      calib_pkg::DT_ONE,   1,   2);
    add_row("half_len0",   calib_pkg::XMARCH,      calib_pkg::DT_HALF,  0,   2);
    add_row("w16_len64",   calib_pkg::XMARCH,      calib_pkg::DT_W16,   64,  128);
    add_row("check_len70", calib_pkg::XMARCH,      calib_pkg::DT_CHECK, 70,  140);
    add_row("addr_len70",  calib_pkg::XMARCH,      calib_pkg::DT_ADDR,  70,  140);
    add_row("full_xmarch", calib_pkg::FULL_XMARCH, calib_pkg::DT_ADDR,  8,   0);
    add_row("addr_len130", calib_pkg::XMARCH,      calib_pkg::DT_ADDR,  130, 260);
  endtask

  // Compares one accepted packet with the model and queues reads for a response
  task automatic record_transfer(calib_pkg::pkt_t got);
    calib_pkg::pkt_t exp_p;
    calib_pkg::pkt_t exp_h;
    calib_pkg::pkt_t got_h;
    int              idx;
    idx = xfer_cnt;
    xfer_cnt++;
    if (idx >= 2 * cur_n) begin
      err_cnt++;
      $display("Run %s sent an extra packet beyond %0d transfers", cur_name, 2 * cur_n);
    end else begin
      exp_p      = expected_pkt(idx, cur_n, cur_dt);
      exp_h      = exp_p;
      exp_h.data = '0;
      got_h      = got;
      got_h.data = '0;
      check_pkt($sformatf("%s packet %0d", cur_name, idx), exp_h, got_h);
      check_data($sformatf("%s packet %0d data", cur_name, idx), exp_p.data, got.data);
      if (exp_p.req_type == calib_pkg::READ) rd_q.push_back(idx - cur_n);
    end
  endtask

  // Scheduler and data handler with random ready, monitor and read responder
  initial begin : bus_model
    calib_pkg::pkt_t rsp_p;
    int              gap;
    int              rd_idx;
    void'($urandom(32'h23ee));
    sched_rdy      = 1'b0;
    intf_pkt_valid = 1'b0;
    intf_pkt       = '0;
    gap            = 0;
    forever begin
      @(posedge clk);
      if (!rst) begin
        if (pgen_pkt_valid) valid_cycles++;
        if (pgen_pkt_valid && sched_rdy) record_transfer(pgen_pkt);
        if (pgen_done) begin
          done_cnt++;
          rsp_at_done = rsp_sent;
          if (pgen_pkt_valid) begin
            err_cnt++;
            $display("Run %s raised done while a packet was offered", cur_name);
          end
        end
      end
      sched_rdy <= (($urandom % 100) < 70);  // Ready about 70% of cycles
      if (gap > 0) begin
        gap--;
        intf_pkt_valid <= 1'b0;
      end else if (rd_q.size() > 0) begin
        rd_idx     = rd_q.pop_front();
        rsp_p      = expected_pkt(rd_idx + cur_n, cur_n, cur_dt);
        rsp_p.data = rsp_p.data ^ tag_word(rd_idx);
        intf_pkt_valid <= 1'b1;
        intf_pkt       <= rsp_p;
        rb_q.push_back(rsp_p.data);
        rsp_sent++;
        gap = $urandom % 4;  // Response spacing 0 to 3 idle cycles
      end else begin
        intf_pkt_valid <= 1'b0;
      end
    end
  end

  task automatic read_back();
    int k;
    check_count({cur_name, " responses captured"}, cur_n, rb_q.size());
    for (k = 0; k < rb_q.size(); k++) begin
      @(posedge clk);
      pgen_rd_ptr <= rptr_t'(k);
      @(posedge clk);  // RAM registers the address
      @(posedge clk);
      check_data($sformatf("%s readback %0d", cur_name, k), rb_q[k], pgen_dout);
    end
  endtask

  task automatic run_row(int r);
    int cycles;
    cur_name     = tbl_name[r];
    cur_dt       = tbl_dt[r];
    cur_n        = tbl_xfers[r] / 2;
    xfer_cnt     = 0;
    valid_cycles = 0;
    done_cnt     = 0;
    rsp_sent     = 0;
    rsp_at_done  = -1;
    rd_q.delete();
    rb_q.delete();
    @(posedge clk);
    march_type     <= tbl_mt[r];
    data_type      <= tbl_dt[r];
    march_len      <= tbl_len[r];
    cal_pgen_start <= 1'b1;
    @(posedge clk);
    cal_pgen_start <= 1'b0;
    cycles = 0;
    while (done_cnt == 0 && cycles < DONE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (done_cnt == 0) begin
      timed_out = 1'b1;
      $display("Timeout: run %s saw no done pulse within %0d cycles", cur_name, DONE_TIMEOUT);
    end else begin
      repeat (SETTLE_CYCLES) @(posedge clk);  // Catch a late packet or second pulse
      check_count({cur_name, " transfers"}, tbl_xfers[r], xfer_cnt);
      check_count({cur_name, " done pulses"}, 1, done_cnt);
      check_count({cur_name, " responses before done"}, cur_n, rsp_at_done);
      if (tbl_xfers[r] == 0) begin
        check_count({cur_name, " valid cycles"}, 0, valid_cycles);
      end else begin
        read_back();
      end
    end
  endtask

  initial begin : main_seq
    int r;
    rst            = 1'b1;
    cal_pgen_start = 1'b0;
    march_type     = calib_pkg::XMARCH;
    data_type      = calib_pkg::DT_ZERO;
    march_len      = '0;
    pgen_rd_ptr    = '0;
    load_table();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    r = 0;
    while (r < tbl_name.size() && !timed_out) begin
      run_row(r);
      r++;
    end
    $display("Summary: %0d runs, %0d checks, %0d errors, timeout %0d",
             r, chk_cnt, err_cnt, timed_out);
    if (timed_out || err_cnt != 0) begin
      $display("SIMULATION FAILED");
    end else begin
      $display("SIMULATION PASSED");
    end
    $finish;
  end

endmodule

/* src/cal_cfg_if.sv */
`timescale 1ns/1ps

// Start strobe and run configuration from the calibration handler
interface cal_cfg_if;

  logic                        start;       // One-cycle start strobe
  calib_pkg::march_e           march_type;
  calib_pkg::data_e            data_type;
  logic [calib_pkg::LEN_W-1:0] march_len;   // Packets per phase where 0 means 1

  // Sequencer needs the whole configuration
  modport seq (
    input start, march_type, data_type, march_len
  );

  // Capture block only restarts its count
  modport cap (
    input start
  );

endinterface

/* src/calib_pkg.sv */
package calib_pkg;

  // Memory address field widths
  localparam int ROW_W  = 14;
  localparam int COL_W  = 10;
  localparam int BK_W   = 4;

  localparam int DATA_W = 256;  // Packet payload
  localparam int PRIO_W = 2;
  localparam int LEN_W  = 32;   // Width of march_len

  // Result memory geometry
  localparam int RES_DEPTH = 4096;
  localparam int RES_AW    = 12;

  // Last row of the X-march walk before the column steps
  localparam logic [ROW_W-1:0] ROW_WRAP = 14'd63;

  typedef enum logic {
    READ  = 1'b0,
    WRITE = 1'b1
  } req_e;

  // March types; FULL_XMARCH is reserved and treated as unsupported
  typedef enum logic [5:0] {
    XMARCH      = 6'd0,
    FULL_XMARCH = 6'd1
  } march_e;

  typedef enum logic [5:0] {
    DT_ZERO  = 6'd0,
    DT_ONE   = 6'd1,
    DT_HALF  = 6'd2,
    DT_W16   = 6'd3,
    DT_CHECK = 6'd4,
    DT_ADDR  = 6'd5
  } data_e;

  // Request packet towards the scheduler and also used for responses
  typedef struct packed {
    req_e              req_type;
    logic [BK_W-1:0]   bk_addr;
    logic [ROW_W-1:0]  row_addr;
    logic [COL_W-1:0]  col_addr;
    logic [DATA_W-1:0] data;
    logic [PRIO_W-1:0] prio;
  } pkt_t;

endpackage

/* src/calib_ptngen.sv */
`timescale 1ns/1ps

module calib_ptngen (
  input  logic                         clk,
  input  logic                         rst,
  // Calibration handler side
  input  logic                         cal_pgen_start,
  input  calib_pkg::march_e            march_type,
  input  calib_pkg::data_e             data_type,
  input  logic [calib_pkg::LEN_W-1:0]  march_len,
  input  logic [calib_pkg::RES_AW-1:0] pgen_rd_ptr,
  output logic [calib_pkg::DATA_W-1:0] pgen_dout,
  output logic                         pgen_done,
  // Scheduler side
  input  logic                         sched_rdy,
  output logic                         pgen_pkt_valid,
  output calib_pkg::pkt_t              pgen_pkt,
  // Read responses from the data handler
  input  logic                         intf_pkt_valid,
  input  calib_pkg::pkt_t              intf_pkt
);

  logic [calib_pkg::LEN_W-1:0]  rsp_cnt;
  logic                         res_wr_en;
  logic [calib_pkg::RES_AW-1:0] res_wr_addr;
  logic [calib_pkg::DATA_W-1:0] res_wr_data;

  cal_cfg_if u_cfg ();

  assign u_cfg.start      = cal_pgen_start;
  assign u_cfg.march_type = march_type;
  assign u_cfg.data_type  = data_type;
  assign u_cfg.march_len  = march_len;

  march_seq u_march_seq (
    .clk       (clk),
    .rst       (rst),
    .cfg       (u_cfg),
    .sched_rdy (sched_rdy),
    .rsp_cnt   (rsp_cnt),
    .pkt_valid (pgen_pkt_valid),
    .pkt       (pgen_pkt),
    .done      (pgen_done)
  );

  resp_capture u_resp_capture (
    .clk       (clk),
    .rst       (rst),
    .cfg       (u_cfg),
    .rsp_valid (intf_pkt_valid),
    .rsp_pkt   (intf_pkt),
    .wr_en     (res_wr_en),
    .wr_addr   (res_wr_addr),
    .wr_data   (res_wr_data),
    .rsp_cnt   (rsp_cnt)
  );

  // Read back is only meaningful while the sequencer is idle
  result_ram u_result_ram (
    .clk     (clk),
    .wr_en   (res_wr_en),
    .wr_addr (res_wr_addr),
    .wr_data (res_wr_data),
    .rd_addr (pgen_rd_ptr),
    .rd_data (pgen_dout)
  );

endmodule

/* src/march_seq.sv */
`timescale 1ns/1ps

module march_seq (
  input  logic                        clk,
  input  logic                        rst,
  cal_cfg_if.seq                      cfg,
  input  logic                        sched_rdy,
  input  logic [calib_pkg::LEN_W-1:0] rsp_cnt,
  output logic                        pkt_valid,
  output calib_pkg::pkt_t             pkt,
  output logic                        done
);

  typedef enum logic [1:0] {
    IDLE,
    XWRITE,
    XREAD,
    WAIT
  } state_e;

  state_e                          state;
  logic [calib_pkg::LEN_W-1:0]     cnt;         // Packets left in phase minus one
  logic [calib_pkg::LEN_W-1:0]     pkt_total;   // N
  logic [calib_pkg::LEN_W-1:0]     last_idx;    // N-1
  logic                            supported;
  logic                            launch;
  logic                            xfer;
  logic                            phase_end;
  logic                            load;
  calib_pkg::req_e                 nxt_req;
  logic [calib_pkg::ROW_W-1:0]     nxt_row;
  logic [calib_pkg::COL_W-1:0]     nxt_col;
  logic [calib_pkg::DATA_W-1:0]    nxt_data;

  // A length of zero still runs one packet per phase
  assign pkt_total = (cfg.march_len == '0) ? {{(calib_pkg::LEN_W-1){1'b0}}, 1'b1}
                                           : cfg.march_len;
  assign last_idx  = pkt_total - 1'b1;

  assign supported = (cfg.march_type == calib_pkg::XMARCH);
  assign launch    = (state == IDLE) && cfg.start && supported;
  assign xfer      = pkt_valid && sched_rdy;
  assign phase_end = (cnt == '0);
  assign load      = launch || (xfer && (state == XWRITE || state == XREAD));

  // Address and type of the packet that follows the current one
  always_comb begin
    nxt_row = '0;
    nxt_col = '0;
    nxt_req = pkt.req_type;
    if (state == IDLE) begin
      nxt_req = calib_pkg::WRITE;  // Every run opens with writes at row 0, col 0
    end else if (phase_end) begin
      nxt_req = calib_pkg::READ;   // Read phase restarts the walk
    end else if (pkt.row_addr == calib_pkg::ROW_WRAP) begin
      nxt_col = pkt.col_addr + 1'b1;
    end else begin
      nxt_row = pkt.row_addr + 1'b1;
      nxt_col = pkt.col_addr;
    end
  end

  ptn_data_gen u_ptn_data_gen (
    .data_type (cfg.data_type),
    .bk_addr   ('0),             // Bank stays 0 for X-march
    .row_addr  (nxt_row),
    .col_addr  (nxt_col),
    .data      (nxt_data)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= IDLE;
      cnt       <= '0;
      pkt_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (cfg.start) begin
            if (supported) begin
              state     <= XWRITE;
              cnt       <= last_idx;
              pkt_valid <= 1'b1;
            end else begin
              done <= 1'b1;  // Nothing to send for this type
            end
          end
        end
        XWRITE: begin
          if (xfer) begin
            if (phase_end) begin
              state <= XREAD;
              cnt   <= last_idx;
            end else begin
              cnt <= cnt - 1'b1;
            end
          end
        end
        XREAD: begin
          if (xfer) begin
            if (phase_end) begin
              state     <= WAIT;
              pkt_valid <= 1'b0;
            end else begin
              cnt <= cnt - 1'b1;
            end
          end
        end
        WAIT: begin
          // Hold until every read has come back
          if (rsp_cnt >= pkt_total) begin
            state <= IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Outgoing packet register
  always_ff @(posedge clk) begin
    if (load) begin
      pkt.req_type <= nxt_req;
      pkt.bk_addr  <= '0;
      pkt.row_addr <= nxt_row;
      pkt.col_addr <= nxt_col;
      pkt.data     <= nxt_data;
      pkt.prio     <= '0;
    end
  end

  // Scheduler may stall; the offered packet must not move
  a_pkt_hold: assert property (@(posedge clk) disable iff (rst)
    pkt_valid && !sched_rdy |=> pkt_valid && $stable(pkt))
    else $error("packet changed while stalled");

  a_done_idle: assert property (@(posedge clk) disable iff (rst)
    !(done && pkt_valid))
    else $error("done raised while a packet is offered");

endmodule

/* src/ptn_data_gen.sv */
`timescale 1ns/1ps

module ptn_data_gen (
  input  calib_pkg::data_e              data_type,
  input  logic [calib_pkg::BK_W-1:0]    bk_addr,
  input  logic [calib_pkg::ROW_W-1:0]   row_addr,
  input  logic [calib_pkg::COL_W-1:0]   col_addr,
  output logic [calib_pkg::DATA_W-1:0]  data
);

  // Bank, row and column each padded up to a byte boundary
  // bank 4b -> 8b, row 14b -> 16b, col 10b -> 16b
  logic [39:0] addr_word;

  assign addr_word = {4'd0, bk_addr, 2'd0, row_addr, 6'd0, col_addr};

  always_comb begin
    data = '0;
    case (data_type)
      calib_pkg::DT_ZERO: begin
        data = '0;
      end
      calib_pkg::DT_ONE: begin
        data = '1;
      end
      calib_pkg::DT_HALF: begin  // Upper half low, lower half high
        data = {{(calib_pkg::DATA_W/2){1'b0}}, {(calib_pkg::DATA_W/2){1'b1}}};
      end
      calib_pkg::DT_W16: begin
        data = {(calib_pkg::DATA_W/32){32'h0000FFFF}};
      end
      calib_pkg::DT_CHECK: begin
        data = {(calib_pkg::DATA_W/32){32'hAAAA5555}};
      end
      calib_pkg::DT_ADDR: begin
        data[$bits(addr_word)-1:0] = addr_word;  // Zero-extended above
      end
      default: begin
        data = '0;  // Unknown code
      end
    endcase
  end

endmodule

/* src/resp_capture.sv */
`timescale 1ns/1ps

module resp_capture (
  input  logic                         clk,
  input  logic                         rst,
  cal_cfg_if.cap                       cfg,
  input  logic                         rsp_valid,
  input  calib_pkg::pkt_t              rsp_pkt,
  output logic                         wr_en,
  output logic [calib_pkg::RES_AW-1:0] wr_addr,
  output logic [calib_pkg::DATA_W-1:0] wr_data,
  output logic [calib_pkg::LEN_W-1:0]  rsp_cnt
);

  logic                         rsp_valid_d;
  logic [calib_pkg::DATA_W-1:0] rsp_data_d;  // Response payload one cycle late

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rsp_valid_d <= 1'b0;
      rsp_cnt     <= '0;
    end else begin
      rsp_valid_d <= rsp_valid;
      if (cfg.start) begin
        rsp_cnt <= '0;            // New run restarts at address 0
      end else if (rsp_valid_d) begin
        rsp_cnt <= rsp_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid) begin
      rsp_data_d <= rsp_pkt.data;
    end
  end

  // Count doubles as the write pointer
  assign wr_en   = rsp_valid_d;
  assign wr_addr = rsp_cnt[calib_pkg::RES_AW-1:0];
  assign wr_data = rsp_data_d;

  // More responses than the result memory holds would wrap over entry 0
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> (rsp_cnt < calib_pkg::RES_DEPTH))
    else $error("result memory full, response dropped");

endmodule

/* src/result_ram.sv */
`timescale 1ns/1ps

module result_ram (
  input  logic                         clk,
  input  logic                         wr_en,
  input  logic [calib_pkg::RES_AW-1:0] wr_addr,
  input  logic [calib_pkg::DATA_W-1:0] wr_data,
  input  logic [calib_pkg::RES_AW-1:0] rd_addr,
  output logic [calib_pkg::DATA_W-1:0] rd_data
);

  logic [calib_pkg::DATA_W-1:0] mem [calib_pkg::RES_DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port returning old data on a same-address collision
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule
